// File: logic/fpa_width_pkg.sv
`default_nettype none

package fpa_width_pkg;

	// mantissa and bus widths
	localparam int mant_w = 40;
	localparam int word_w = 16;
	localparam int byte_w = 8;
	localparam int flag_w = 4;

	// T segment boundaries, lsb of each field
	localparam int seg_hi_lsb = 24;
	localparam int seg_mid_lsb = 8;

	// top adder chunk, above the two 16-bit carry points
	localparam int hi_w = mant_w - 2 * word_w;

	// bit 39 is the sign
	typedef logic [mant_w-1:0] mant_t;

	// input word and readout word
	typedef logic [word_w-1:0] word_t;

	// zero, minus, overflow, carry from msb down
	typedef logic [flag_w-1:0] flags_t;

endpackage

`default_nettype wire

// File: logic/fpa_ops_pkg.sv
`default_nettype none

package fpa_ops_pkg;
	import fpa_width_pkg::*;

	// command opcodes
	typedef enum logic [3:0] {
		op_nop = 4'd0,
		op_ldt = 4'd1,
		op_shl = 4'd2,
		op_shr = 4'd3,
		op_t2m = 4'd4,
		op_t2c = 4'd5,
		op_m2t = 4'd6,
		op_add = 4'd7,
		op_sub = 4'd8,
		op_clr = 4'd9
	} fpa_op_t;

	// readout / load segment select
	typedef enum logic [1:0] {
		seg_hi = 2'd0,
		seg_mid = 2'd1,
		seg_lo = 2'd2,
		seg_flags = 2'd3
	} seg_t;

	// K source code for T, and per-segment write enable
	typedef logic [2:0] ksel_t;
	typedef logic [2:0] segmask_t;

	localparam ksel_t ksel_zero = 3'd0;
	localparam ksel_t ksel_word = 3'd1;
	localparam ksel_t ksel_sum = 3'd2;
	localparam ksel_t ksel_m = 3'd3;
	localparam ksel_t ksel_shl = 3'd4;
	localparam ksel_t ksel_shr = 3'd5;

	localparam segmask_t mask_none = 3'b000;
	localparam segmask_t mask_hi = 3'b100;
	localparam segmask_t mask_mid = 3'b010;
	localparam segmask_t mask_lo = 3'b001;
	localparam segmask_t mask_all = 3'b111;

	// flag bit positions
	localparam int flag_z = 3;
	localparam int flag_n = 2;
	localparam int flag_v = 1;
	localparam int flag_c = 0;

	// zero padding below short readout fields
	localparam int lo_pad_w = word_w - byte_w;
	localparam int flag_pad_w = word_w - flag_w;

endpackage

`default_nettype wire

// File: logic/fpa_decode.sv
`default_nettype none

module fpa_decode
	import fpa_width_pkg::*;
	import fpa_ops_pkg::*;
(
	input  logic     cclk,
	input  logic     reset,
	input  logic     cmd_valid,
	input  fpa_op_t  cmd_op,
	input  seg_t     cmd_seg,
	input  word_t    cmd_word,
	output logic     dec_valid,
	output seg_t     dec_seg,
	output word_t    dec_word,
	output ksel_t    t_sel,
	output segmask_t t_mask,
	output logic     m_load,
	output logic     c_load,
	output logic     flag_load,
	output logic     alu_sub,
	output logic     clear
);

	// controls for the next stage, before the register
	ksel_t    sel_nxt;
	segmask_t mask_nxt;
	logic     m_nxt;
	logic     c_nxt;
	logic     flag_nxt;
	logic     sub_nxt;
	logic     clr_nxt;

	always_comb begin
		sel_nxt = ksel_zero;
		mask_nxt = mask_none;
		m_nxt = 1'b0;
		c_nxt = 1'b0;
		flag_nxt = 1'b0;
		sub_nxt = 1'b0;
		clr_nxt = 1'b0;
		// idle cycles decode to no writes at all
		if (cmd_valid) begin
			case (cmd_op)
				op_ldt: begin
					sel_nxt = ksel_word;
					// one segment only, flags select loads nothing
					case (cmd_seg)
						seg_hi: mask_nxt = mask_hi;
						seg_mid: mask_nxt = mask_mid;
						seg_lo: mask_nxt = mask_lo;
						default: mask_nxt = mask_none;
					endcase
				end
				op_shl: begin
					sel_nxt = ksel_shl;
					mask_nxt = mask_all;
				end
				op_shr: begin
					sel_nxt = ksel_shr;
					mask_nxt = mask_all;
				end
				op_t2m: m_nxt = 1'b1;
				op_t2c: c_nxt = 1'b1;
				op_m2t: begin
					sel_nxt = ksel_m;
					mask_nxt = mask_all;
				end
				op_add, op_sub: begin
					sel_nxt = ksel_sum;
					mask_nxt = mask_all;
					flag_nxt = 1'b1;
					sub_nxt = (cmd_op == op_sub);
				end
				op_clr: clr_nxt = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			t_sel <= ksel_zero;
			t_mask <= mask_none;
			m_load <= 1'b0;
			c_load <= 1'b0;
			flag_load <= 1'b0;
			alu_sub <= 1'b0;
			clear <= 1'b0;
		end else begin
			dec_valid <= cmd_valid;
			t_sel <= sel_nxt;
			t_mask <= mask_nxt;
			m_load <= m_nxt;
			c_load <= c_nxt;
			flag_load <= flag_nxt;
			alu_sub <= sub_nxt;
			clear <= clr_nxt;
		end
	end

	// segment select and word ride along with the command
	always_ff @(posedge cclk) begin
		if (cmd_valid) begin
			dec_seg <= cmd_seg;
			dec_word <= cmd_word;
		end
	end

	// opcodes above op_clr are not part of the command set
	a_op_defined: assert property (@(posedge cclk) disable iff (reset)
		cmd_valid |-> (!$isunknown(cmd_op) && cmd_op <= op_clr));

endmodule

`default_nettype wire

// File: logic/fpa_alu.sv
`default_nettype none

module fpa_alu
	import fpa_width_pkg::*;
(
	input  mant_t t,
	input  mant_t c,
	input  logic  sub,
	output mant_t sum,
	output logic  carry,
	output logic  overflow,
	output logic  carry16,
	output logic  carry32
);

	// second operand, inverted for subtract
	mant_t b;

	// three chunks so the 16 and 32 bit carries fall out directly
	logic [word_w:0] sum_lo;
	logic [word_w:0] sum_mid;
	logic [hi_w:0]   sum_hi;

	assign b = sub ? ~c : c;

	// plus one for two's complement enters as carry in
	assign sum_lo = {1'b0, t[word_w-1:0]} + {1'b0, b[word_w-1:0]}
		+ {{word_w{1'b0}}, sub};
	assign carry16 = sum_lo[word_w];

	assign sum_mid = {1'b0, t[2*word_w-1:word_w]} + {1'b0, b[2*word_w-1:word_w]}
		+ {{word_w{1'b0}}, carry16};
	assign carry32 = sum_mid[word_w];

	assign sum_hi = {1'b0, t[mant_w-1:2*word_w]} + {1'b0, b[mant_w-1:2*word_w]}
		+ {{hi_w{1'b0}}, carry32};

	// on subtract this is the no-borrow carry
	assign carry = sum_hi[hi_w];

	assign sum = {sum_hi[hi_w-1:0], sum_mid[word_w-1:0], sum_lo[word_w-1:0]};

	// like signs in, different sign out
	assign overflow = (t[mant_w-1] == b[mant_w-1]) && (sum[mant_w-1] != t[mant_w-1]);

endmodule

`default_nettype wire

// File: logic/fpa_regs.sv
`default_nettype none

module fpa_regs
	import fpa_width_pkg::*;
	import fpa_ops_pkg::*;
(
	input  logic     cclk,
	input  logic     reset,
	input  logic     dec_valid,
	input  seg_t     dec_seg,
	input  word_t    dec_word,
	input  ksel_t    t_sel,
	input  segmask_t t_mask,
	input  logic     m_load,
	input  logic     c_load,
	input  logic     flag_load,
	input  logic     sub_req,
	input  logic     clear,
	input  mant_t    sum,
	input  logic     carry,
	input  logic     overflow,
	output mant_t    t,
	output mant_t    c,
	output flags_t   flags,
	output seg_t     rsp_seg,
	output logic     reg_valid,
	output logic     alu_sub
);

	// K bus, source for every T write
	mant_t k;
	mant_t m_q;
	logic  carry_q;
	logic  ovf_q;

	// adder stays in add mode unless a subtract is in this stage
	assign alu_sub = sub_req & flag_load;

	always_comb begin
		case (t_sel)
			// word copied into every segment, mask picks the one that lands
			ksel_word: k = {dec_word, dec_word, dec_word[word_w-1 -: byte_w]};
			ksel_sum: k = sum;
			ksel_m: k = m_q;
			// left fills zero
			ksel_shl: k = {t[mant_w-2:0], 1'b0};
			// right keeps the sign
			ksel_shr: k = {t[mant_w-1], t[mant_w-1:1]};
			default: k = '0;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (reset || clear) begin
			t <= '0;
			m_q <= '0;
			c <= '0;
			carry_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			// per-segment writes of T
			if (|(t_mask & mask_hi))
				t[mant_w-1:seg_hi_lsb] <= k[mant_w-1:seg_hi_lsb];
			if (|(t_mask & mask_mid))
				t[seg_hi_lsb-1:seg_mid_lsb] <= k[seg_hi_lsb-1:seg_mid_lsb];
			if (|(t_mask & mask_lo))
				t[seg_mid_lsb-1:0] <= k[seg_mid_lsb-1:0];
			if (m_load)
				m_q <= t;
			if (c_load)
				c <= t;
			// carry and overflow only from add/sub
			if (flag_load) begin
				carry_q <= carry;
				ovf_q <= overflow;
			end
		end
	end

	// zero and minus follow T directly
	always_comb begin
		flags = '0;
		flags[flag_z] = (t == '0);
		flags[flag_n] = t[mant_w-1];
		flags[flag_v] = ovf_q;
		flags[flag_c] = carry_q;
	end

	always_ff @(posedge cclk) begin
		if (reset)
			reg_valid <= 1'b0;
		else
			reg_valid <= dec_valid;
	end

	// readout select for the next stage
	always_ff @(posedge cclk) begin
		if (dec_valid)
			rsp_seg <= dec_seg;
	end

	// decode never mixes clear with a write
	a_clear_alone: assert property (@(posedge cclk) disable iff (reset)
		clear |-> !(|t_mask || m_load || c_load || flag_load));

endmodule

`default_nettype wire

// File: logic/fpa_readout.sv
`default_nettype none

module fpa_readout
	import fpa_width_pkg::*;
	import fpa_ops_pkg::*;
(
	input  logic   cclk,
	input  logic   reset,
	input  logic   reg_valid,
	input  seg_t   rsp_seg,
	input  mant_t  t,
	input  flags_t flags,
	output logic   rsp_valid,
	output word_t  rsp_word
);

	always_ff @(posedge cclk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			rsp_word <= '0;
		end else begin
			rsp_valid <= reg_valid;
			// T here already holds this command's own update
			if (reg_valid) begin
				case (rsp_seg)
					seg_hi: rsp_word <= t[mant_w-1:seg_hi_lsb];
					seg_mid: rsp_word <= t[seg_hi_lsb-1:seg_mid_lsb];
					// low byte sits in the upper half
					seg_lo: rsp_word <= {t[seg_mid_lsb-1:0], {lo_pad_w{1'b0}}};
					default: rsp_word <= {flags, {flag_pad_w{1'b0}}};
				endcase
			end
		end
	end

	// nothing in flight survives reset
	a_quiet_after_reset: assert property (@(posedge cclk)
		reset ##1 !reset |=> !rsp_valid);

endmodule

`default_nettype wire

// File: logic/fpa_top.sv
`default_nettype none

module fpa_top
	import fpa_width_pkg::*;
	import fpa_ops_pkg::*;
(
	input  logic    cclk,
	input  logic    reset,
	input  logic    cmd_valid,
	input  fpa_op_t cmd_op,
	input  seg_t    cmd_seg,
	input  word_t   cmd_word,
	output logic    rsp_valid,
	output word_t   rsp_word
);

	// decode to regs
	logic     dec_valid;
	seg_t     dec_seg;
	word_t    dec_word;
	ksel_t    t_sel;
	segmask_t t_mask;
	logic     m_load;
	logic     c_load;
	logic     flag_load;
	logic     dec_sub;
	logic     clear;

	// regs to alu and readout
	mant_t  t;
	mant_t  c;
	flags_t flags;
	seg_t   rsp_seg;
	logic   reg_valid;
	logic   alu_sub;

	// alu back to regs
	mant_t sum;
	logic  carry;
	logic  overflow;

	fpa_decode decode_i (
		.cclk      (cclk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_seg   (cmd_seg),
		.cmd_word  (cmd_word),
		.dec_valid (dec_valid),
		.dec_seg   (dec_seg),
		.dec_word  (dec_word),
		.t_sel     (t_sel),
		.t_mask    (t_mask),
		.m_load    (m_load),
		.c_load    (c_load),
		.flag_load (flag_load),
		.alu_sub   (dec_sub),
		.clear     (clear)
	);

	fpa_regs regs_i (
		.cclk      (cclk),
		.reset     (reset),
		.dec_valid (dec_valid),
		.dec_seg   (dec_seg),
		.dec_word  (dec_word),
		.t_sel     (t_sel),
		.t_mask    (t_mask),
		.m_load    (m_load),
		.c_load    (c_load),
		.flag_load (flag_load),
		.sub_req   (dec_sub),
		.clear     (clear),
		.sum       (sum),
		.carry     (carry),
		.overflow  (overflow),
		.t         (t),
		.c         (c),
		.flags     (flags),
		.rsp_seg   (rsp_seg),
		.reg_valid (reg_valid),
		.alu_sub   (alu_sub)
	);

	// segment carries are left open until multiply/divide sequencing exists
	fpa_alu alu_i (
		.t        (t),
		.c        (c),
		.sub      (alu_sub),
		.sum      (sum),
		.carry    (carry),
		.overflow (overflow),
		.carry16  (),
		.carry32  ()
	);

	fpa_readout readout_i (
		.cclk      (cclk),
		.reset     (reset),
		.reg_valid (reg_valid),
		.rsp_seg   (rsp_seg),
		.t         (t),
		.flags     (flags),
		.rsp_valid (rsp_valid),
		.rsp_word  (rsp_word)
	);

endmodule

`default_nettype wire

// File: test/fpa_tb.sv
`default_nettype none

module fpa_tb
	import fpa_width_pkg::*;
	import fpa_ops_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic    cclk;
	logic    reset;
	logic    cmd_valid;
	fpa_op_t cmd_op;
	seg_t    cmd_seg;
	word_t   cmd_word;
	logic    rsp_valid;
	word_t   rsp_word;

	// stimulus table, one command per entry
	string   tb_name[$];
	fpa_op_t tb_op[$];
	seg_t    tb_seg[$];
	word_t   tb_word[$];
	word_t   tb_exp[$];
	// set when the next entry follows on the very next cycle
	bit      tb_burst[$];

	// every response seen, in arrival order
	word_t rsp_q[$];

	// cycle stamps of each command and each response
	int cyc;
	int cmd_cyc[$];
	int rsp_cyc[$];

	logic [31:0] lcg_state;
	int          errors;
	int          passes;

	fpa_top dut_i (
		.cclk      (cclk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_seg   (cmd_seg),
		.cmd_word  (cmd_word),
		.rsp_valid (rsp_valid),
		.rsp_word  (rsp_word)
	);

	initial begin
		cclk = 1'b0;
		forever #20 cclk = ~cclk;
	end

	// rising edges since time zero
	always @(posedge cclk) begin
		cyc++;
	end

	// collect mid-cycle, away from the rising edge
	always @(negedge cclk) begin
		if (rsp_valid === 1'b1) begin
			rsp_q.push_back(rsp_word);
			rsp_cyc.push_back(cyc);
		end
	end

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// reference flag word for T plus C, from the flag rules
	function automatic word_t add_flags(input mant_t a, input mant_t b);
		logic [mant_w:0] wide;
		logic [mant_w:0] swide;
		mant_t s;
		logic z;
		logic n;
		logic v;
		logic cy;
		wide = {1'b0, a} + {1'b0, b};
		s = wide[mant_w-1:0];
		z = (s == '0);
		n = s[mant_w-1];
		// signed sum one bit wider, out of range when its top two bits differ
		swide = {a[mant_w-1], a} + {b[mant_w-1], b};
		v = swide[mant_w] ^ swide[mant_w-1];
		cy = wide[mant_w];
		return {z, n, v, cy, 12'h000};
	endfunction

	task automatic add_entry(input string name, input fpa_op_t op, input seg_t seg,
		input word_t word, input word_t exp, input bit burst);
		tb_name.push_back(name);
		tb_op.push_back(op);
		tb_seg.push_back(seg);
		tb_word.push_back(word);
		tb_exp.push_back(exp);
		tb_burst.push_back(burst);
	endtask

	// load a 40-bit value, each load reads back its own segment
	task automatic load_value(input string name, input mant_t v, input word_t junk);
		add_entry({name, "_hi"}, op_ldt, seg_hi, v[39:24], v[39:24], 1'b1);
		add_entry({name, "_mid"}, op_ldt, seg_mid, v[23:8], v[23:8], 1'b1);
		// lower input byte must be ignored
		add_entry({name, "_lo"}, op_ldt, seg_lo, {v[7:0], junk[7:0]}, {v[7:0], 8'h00}, 1'b1);
	endtask

	task automatic add_random_pairs();
		mant_t a;
		mant_t b;
		mant_t s;
		logic [31:0] r;
		string nm;
		for (int p = 0; p < 8; p++) begin
			nm = $sformatf("rnd%0d", p);
			r = next_rand();
			a[39:32] = r[7:0];
			a[31:0] = next_rand();
			b[39:32] = r[15:8];
			b[31:0] = next_rand();
			s = a + b;
			load_value({nm, "_a"}, a, r[31:16]);
			add_entry({nm, "_t2c"}, op_t2c, seg_hi, 16'h0000, a[39:24], 1'b1);
			load_value({nm, "_b"}, b, r[23:8]);
			add_entry({nm, "_add"}, op_add, seg_flags, 16'h0000, add_flags(a, b), 1'b1);
			add_entry({nm, "_sum_hi"}, op_nop, seg_hi, 16'h0000, s[39:24], 1'b1);
			add_entry({nm, "_sum_mid"}, op_nop, seg_mid, 16'h0000, s[23:8], 1'b1);
			// only the very last entry closes the burst
			add_entry({nm, "_sum_lo"}, op_nop, seg_lo, 16'h0000, {s[7:0], 8'h00}, p != 7);
		end
	endtask

	task automatic build_table();
		// flag word is zero, minus, overflow, carry in bits 15..12
		add_entry("reset_flags", op_nop, seg_flags, 16'h0000, 16'h8000, 1'b0);
		add_entry("load_hi", op_ldt, seg_hi, 16'h1234, 16'h1234, 1'b0);
		add_entry("load_mid", op_ldt, seg_mid, 16'h5678, 16'h5678, 1'b0);
		add_entry("load_lo", op_ldt, seg_lo, 16'h9abc, 16'h9a00, 1'b0);
		add_entry("read_hi", op_nop, seg_hi, 16'h0000, 16'h1234, 1'b0);
		add_entry("read_mid", op_nop, seg_mid, 16'h0000, 16'h5678, 1'b0);
		add_entry("read_lo", op_nop, seg_lo, 16'h0000, 16'h9a00, 1'b0);
		// all ones into C, then T = 1
		add_entry("ones_hi", op_ldt, seg_hi, 16'hffff, 16'hffff, 1'b0);
		add_entry("ones_mid", op_ldt, seg_mid, 16'hffff, 16'hffff, 1'b0);
		add_entry("ones_lo", op_ldt, seg_lo, 16'hff00, 16'hff00, 1'b0);
		add_entry("ones_t2c", op_t2c, seg_hi, 16'h0000, 16'hffff, 1'b0);
		add_entry("one_hi", op_ldt, seg_hi, 16'h0000, 16'h0000, 1'b0);
		add_entry("one_mid", op_ldt, seg_mid, 16'h0000, 16'h0000, 1'b0);
		add_entry("one_lo", op_ldt, seg_lo, 16'h0100, 16'h0100, 1'b0);
		add_entry("wrap_add", op_add, seg_flags, 16'h0000, 16'h9000, 1'b0);
		add_entry("wrap_hi", op_nop, seg_hi, 16'h0000, 16'h0000, 1'b0);
		// equal values, then a larger subtrahend
		add_entry("eq_hi", op_ldt, seg_hi, 16'h0012, 16'h0012, 1'b0);
		add_entry("eq_t2c", op_t2c, seg_hi, 16'h0000, 16'h0012, 1'b0);
		add_entry("eq_sub", op_sub, seg_flags, 16'h0000, 16'h9000, 1'b0);
		add_entry("neg_sub", op_sub, seg_flags, 16'h0000, 16'h4000, 1'b0);
		add_entry("neg_hi", op_nop, seg_hi, 16'h0000, 16'hffee, 1'b0);
		// 0x60.. plus 0x60.. leaves the positive range
		add_entry("big_hi", op_ldt, seg_hi, 16'h6000, 16'h6000, 1'b0);
		add_entry("big_t2c", op_t2c, seg_hi, 16'h0000, 16'h6000, 1'b0);
		add_entry("big_add", op_add, seg_flags, 16'h0000, 16'h6000, 1'b0);
		add_entry("big_sum", op_nop, seg_hi, 16'h0000, 16'hc000, 1'b0);
		// T = 0xc0_0000_0001, sign set
		add_entry("sh_lo", op_ldt, seg_lo, 16'h0100, 16'h0100, 1'b0);
		add_entry("shr_hi", op_shr, seg_hi, 16'h0000, 16'he000, 1'b0);
		add_entry("shr_lo", op_nop, seg_lo, 16'h0000, 16'h0000, 1'b0);
		add_entry("sh_lo2", op_ldt, seg_lo, 16'h8100, 16'h8100, 1'b0);
		add_entry("shl_lo", op_shl, seg_lo, 16'h0000, 16'h0200, 1'b0);
		add_entry("shl_mid", op_nop, seg_mid, 16'h0000, 16'h0001, 1'b0);
		add_entry("shl_hi", op_nop, seg_hi, 16'h0000, 16'hc000, 1'b0);
		// M survives a T load, but not a clear
		add_entry("t2m", op_t2m, seg_hi, 16'h0000, 16'hc000, 1'b0);
		add_entry("t_wipe", op_ldt, seg_hi, 16'h0000, 16'h0000, 1'b0);
		add_entry("m2t", op_m2t, seg_hi, 16'h0000, 16'hc000, 1'b0);
		add_entry("clr", op_clr, seg_flags, 16'h0000, 16'h8000, 1'b0);
		add_entry("m2t_clr", op_m2t, seg_hi, 16'h0000, 16'h0000, 1'b0);
		add_entry("clr_flags", op_nop, seg_flags, 16'h0000, 16'h8000, 1'b0);
		add_random_pairs();
	endtask

	task automatic drive_entry(input int k);
		cmd_valid = 1'b1;
		cmd_op = tb_op[k];
		cmd_seg = tb_seg[k];
		cmd_word = tb_word[k];
	endtask

	task automatic check_entry(input int k);
		if (rsp_q[k] !== tb_exp[k]) begin
			$display("ERR %s expected %h actual %h", tb_name[k], tb_exp[k], rsp_q[k]);
			errors++;
		end else if (rsp_cyc[k] - cmd_cyc[k] != 3) begin
			// fixed latency, counted from the edge the command is driven after
			$display("ERR %s latency expected 3 actual %0d", tb_name[k],
				rsp_cyc[k] - cmd_cyc[k]);
			errors++;
		end else begin
			$display("ok  %s %h", tb_name[k], rsp_q[k]);
			passes++;
		end
	endtask

	initial begin
		int issued;
		int checked;
		int cycles;
		bit aborted;
		cmd_valid = 1'b0;
		cmd_op = op_nop;
		cmd_seg = seg_hi;
		cmd_word = '0;
		reset = 1'b1;
		lcg_state = 32'h468d2e9f;
		errors = 0;
		passes = 0;
		issued = 0;
		checked = 0;
		aborted = 1'b0;
		build_table();

		repeat (2) @(posedge cclk);
		#2 reset = 1'b0;

		// idle pipeline stays quiet after reset
		cycles = 0;
		repeat (3) begin
			@(negedge cclk);
			if (rsp_valid !== 1'b0)
				cycles++;
		end
		if (cycles != 0) begin
			$display("reset_quiet: rsp_valid went high with no command issued");
			errors++;
		end else begin
			$display("ok  reset_quiet");
			passes++;
		end

		while (issued < tb_name.size() && !aborted) begin
			@(posedge cclk);
			#2 drive_entry(issued);
			cmd_cyc.push_back(cyc);
			issued++;
			if (!tb_burst[issued-1]) begin
				@(posedge cclk);
				#2 cmd_valid = 1'b0;
				// bounded wait for everything still in flight
				cycles = 0;
				while (rsp_q.size() < issued && cycles < 10) begin
					@(posedge cclk);
					cycles++;
				end
				if (rsp_q.size() < issued) begin
					$display("timeout: %s got no response within 10 cycles",
						tb_name[issued-1]);
					errors++;
					aborted = 1'b1;
				end else begin
					while (checked < issued) begin
						check_entry(checked);
						checked++;
					end
				end
			end
		end

		// a few idle cycles to catch stray responses
		repeat (4) @(posedge cclk);
		if (!aborted && rsp_q.size() != issued) begin
			$display("response count wrong: %0d commands gave %0d responses",
				issued, rsp_q.size());
			errors++;
		end

		$display("tests passed %0d, errors %0d", passes, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/fpa_width_pkg.sv
logic/fpa_ops_pkg.sv
logic/fpa_decode.sv
logic/fpa_alu.sv
logic/fpa_regs.sv
logic/fpa_readout.sv
logic/fpa_top.sv
test/fpa_tb.sv

// File: Bender.yml
package:
  name: fpa_datapath

sources:
  # rtl
  - files:
      - logic/fpa_width_pkg.sv
      - logic/fpa_ops_pkg.sv
      - logic/fpa_decode.sv
      - logic/fpa_alu.sv
      - logic/fpa_regs.sv
      - logic/fpa_readout.sv
      - logic/fpa_top.sv
  # test
  - target: test
    files:
      - test/fpa_tb.sv
